//--- in_crc16.sv
// ----------------------------------------------------------------------
// USB CRC16 accumulator over the data bytes of one packet.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module in_crc16 (
   input  wire         clk_i,
   input  wire         rstn_i,
   input  wire         crc_clear_i,
   input  wire         crc_update_i,
   input  wire  [7:0]  crc_data_i,
   output logic [15:0] crc_o
);
   import in_ep_pkg::*;

   logic [15:0] crc_q;

   // Absorbs one byte, LSB first, reflected polynomial.
   function automatic logic [15:0] crc_byte(input logic [15:0] crc, input logic [7:0] data);
      logic [15:0] c;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ CRC16_POLY_REFL;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         crc_q <= CRC16_INIT;
      end else if (crc_clear_i) begin
         crc_q <= CRC16_INIT;
      end else if (crc_update_i) begin
         crc_q <= crc_byte(crc_q, crc_data_i);
      end
   end

   // Transmitted inverted, low byte first.
   assign crc_o = ~crc_q;

endmodule

`default_nettype wire

//--- in_ep_ctrl.sv
// ----------------------------------------------------------------------
// IN endpoint controller.
// Sequences token, PID, data, CRC and handshake, keeps the data
// toggle and decides between FIFO commit and rewind.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module in_ep_ctrl #(
   parameter int MAX_PKT = 8
) (
   input  wire                clk_i,
   input  wire                rstn_i,
   // Host events.
   input  wire                in_token_i,
   input  wire                ack_i,
   input  wire                hs_timeout_i,
   input  wire                tx_ready_i,
   // FIFO.
   input  wire                in_valid_i,
   input  wire                in_empty_i,
   output logic               in_req_o,
   output logic               in_ready_o,
   output logic               in_commit_o,
   // CRC.
   output logic               crc_clear_o,
   output logic               crc_update_o,
   // Packet builder.
   output in_ep_pkg::tx_sel_e tx_sel_o,
   output in_ep_pkg::pid_e    tx_pid_o,
   output logic               tx_valid_o,
   output logic               tx_last_o,
   // Status.
   output logic               busy_o,
   output logic               toggle_o
);
   import in_ep_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PID,
      ST_DATA,
      ST_CRC_LO,
      ST_CRC_HI,
      ST_WAIT_HS,
      ST_COMMIT
   } state_e;

   localparam int CNT_W = $clog2(MAX_PKT + 1);

   state_e           state_q;
   pid_e             pid_q;
   logic [CNT_W-1:0] cnt_q;
   logic             toggle_q;
   logic             busy_q;
   logic             in_req_q;
   logic             start;
   logic             data_avail;
   logic             data_take;

   // Tokens only start a transaction from idle.
   assign start      = (state_q == ST_IDLE) && in_token_i;
   assign data_avail = in_valid_i && (cnt_q < CNT_W'(MAX_PKT));
   assign data_take  = (state_q == ST_DATA) && data_avail && tx_ready_i;

   assign in_req_o     = in_req_q;
   assign in_ready_o   = data_take;
   assign crc_update_o = data_take;
   assign crc_clear_o  = start;
   assign in_commit_o  = (state_q == ST_COMMIT);
   assign busy_o       = busy_q;
   assign toggle_o     = toggle_q;
   assign tx_pid_o     = pid_q;

   always_comb begin
      case (state_q)
         ST_DATA:   tx_sel_o = SEL_DATA;
         ST_CRC_LO: tx_sel_o = SEL_CRC_LO;
         ST_CRC_HI: tx_sel_o = SEL_CRC_HI;
         default:   tx_sel_o = SEL_PID;
      endcase
   end

   assign tx_valid_o = (state_q == ST_PID) || (state_q == ST_CRC_LO) ||
                       (state_q == ST_CRC_HI) || ((state_q == ST_DATA) && data_avail);
   assign tx_last_o  = (state_q == ST_CRC_HI) ||
                       ((state_q == ST_PID) && (pid_q == PID_NAK));

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q  <= ST_IDLE;
         pid_q    <= PID_DATA0;
         cnt_q    <= '0;
         toggle_q <= 1'b0;
         busy_q   <= 1'b0;
         in_req_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (start) begin
                  busy_q   <= 1'b1;
                  in_req_q <= 1'b1;
                  cnt_q    <= '0;
                  if (in_empty_i) begin
                     pid_q <= PID_NAK;
                  end else begin
                     pid_q <= toggle_q ? PID_DATA1 : PID_DATA0;
                  end
                  state_q <= ST_PID;
               end
            end
            ST_PID: begin
               if (tx_ready_i) begin
                  if (pid_q == PID_NAK) begin
                     // NAK ends the transaction without a handshake.
                     busy_q   <= 1'b0;
                     in_req_q <= 1'b0;
                     state_q  <= ST_IDLE;
                  end else begin
                     state_q <= ST_DATA;
                  end
               end
            end
            ST_DATA: begin
               if (!data_avail) begin
                  state_q <= ST_CRC_LO;
               end else if (tx_ready_i) begin
                  cnt_q <= cnt_q + 1'b1;
               end
            end
            ST_CRC_LO: begin
               if (tx_ready_i) begin
                  state_q <= ST_CRC_HI;
               end
            end
            ST_CRC_HI: begin
               if (tx_ready_i) begin
                  state_q <= ST_WAIT_HS;
               end
            end
            ST_WAIT_HS: begin
               if (ack_i) begin
                  toggle_q <= !toggle_q;
                  busy_q   <= 1'b0;
                  in_req_q <= 1'b0;
                  state_q  <= ST_COMMIT;
               end else if (hs_timeout_i) begin
                  // FIFO rewinds at the next request.
                  busy_q   <= 1'b0;
                  in_req_q <= 1'b0;
                  state_q  <= ST_IDLE;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- in_ep_pkg.sv
// ----------------------------------------------------------------------
// Shared definitions for the USB full-speed IN endpoint.
// PID byte values, transmit byte source select, transmit byte struct
// and the reflected CRC16 constants.
// ----------------------------------------------------------------------
`default_nettype none

package in_ep_pkg;

   // PID bytes as they appear on the wire, check nibble included.
   typedef enum logic [7:0] {
      PID_DATA0 = 8'hC3,
      PID_DATA1 = 8'h4B,
      PID_NAK   = 8'h5A
   } pid_e;

   // Source of the byte placed on the transmit port.
   typedef enum logic [1:0] {
      SEL_PID,
      SEL_DATA,
      SEL_CRC_LO,
      SEL_CRC_HI
   } tx_sel_e;

   // One packet byte toward the host.
   // Last marks the final byte of the packet.
   typedef struct packed {
      logic       valid;
      logic       last;
      logic [7:0] data;
   } tx_byte_t;

   // USB CRC16, processed LSB first.
   localparam logic [15:0] CRC16_INIT      = 16'hFFFF;
   localparam logic [15:0] CRC16_POLY_REFL = 16'hA001;

endpackage

`default_nettype wire

//--- in_fifo.sv
// ----------------------------------------------------------------------
// Circular IN FIFO with paced application writes.
// Working read pointer rewinds at each new request and is
// copied to the committed pointer when the host acknowledges.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module in_fifo #(
   parameter int MAX_PKT     = 8,
   parameter int BIT_SAMPLES = 4
) (
   input  wire        clk_i,
   input  wire        rstn_i,
   // Application write port.
   input  wire  [7:0] app_in_data_i,
   input  wire        app_in_valid_i,
   output logic       app_in_ready_o,
   // Endpoint read port.
   input  wire        in_req_i,
   input  wire        in_ready_i,
   input  wire        in_commit_i,
   output logic [7:0] in_data_o,
   output logic       in_valid_o,
   // Status.
   output logic       in_empty_o,
   output logic       in_full_o
);

   // One spare slot tells full from empty.
   localparam int DEPTH = MAX_PKT + 1;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = (BIT_SAMPLES > 1) ? $clog2(BIT_SAMPLES) : 1;
   localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] PACE_DONE = CNT_W'(BIT_SAMPLES - 1);

   logic [7:0]       mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_commit_q;
   logic [PTR_W-1:0] rd_work_q;
   logic [CNT_W-1:0] pace_cnt_q;
   logic             in_req_q;
   logic             req_rise;
   logic             wr_en;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == LAST_SLOT) ? '0 : ptr + 1'b1;
   endfunction

   // Fullness is taken against the committed pointer, so bytes that
   // were sent but not yet acknowledged are never overwritten.
   assign in_empty_o = (rd_commit_q == wr_ptr_q);
   assign in_full_o  = (next_ptr(wr_ptr_q) == rd_commit_q);

   // Write side.
   assign app_in_ready_o = !in_full_o && (pace_cnt_q == PACE_DONE);
   assign wr_en          = app_in_valid_i && app_in_ready_o;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         pace_cnt_q <= '0;
         wr_ptr_q   <= '0;
      end else if (wr_en) begin
         pace_cnt_q <= '0;
         wr_ptr_q   <= next_ptr(wr_ptr_q);
      end else if (pace_cnt_q != PACE_DONE) begin
         // Holds one byte per BIT_SAMPLES clocks.
         pace_cnt_q <= pace_cnt_q + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem_q[wr_ptr_q] <= app_in_data_i;
      end
   end

   // Read side.
   assign req_rise = in_req_i && !in_req_q;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         in_req_q    <= 1'b0;
         rd_commit_q <= '0;
         rd_work_q   <= '0;
      end else begin
         in_req_q <= in_req_i;
         if (req_rise) begin
            // New transaction starts from the last acknowledged byte.
            rd_work_q <= rd_commit_q;
         end else if (in_ready_i && in_valid_o) begin
            rd_work_q <= next_ptr(rd_work_q);
         end
         if (in_commit_i) begin
            rd_commit_q <= rd_work_q;
         end
      end
   end

   // Data is offered once the rewind has taken effect.
   assign in_valid_o = in_req_i && in_req_q && (rd_work_q != wr_ptr_q);
   assign in_data_o  = mem_q[rd_work_q];

endmodule

`default_nettype wire

//--- in_pkt_tx.sv
// ----------------------------------------------------------------------
// Packet byte builder.
// Selects PID, FIFO data or CRC bytes and holds one byte at a time
// on the transmit port until the host consumes it.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module in_pkt_tx (
   input  wire                  clk_i,
   input  wire                  rstn_i,
   // From the endpoint controller.
   input  wire in_ep_pkg::tx_sel_e tx_sel_i,
   input  wire in_ep_pkg::pid_e    tx_pid_i,
   input  wire                  tx_valid_i,
   input  wire                  tx_last_i,
   // Byte sources.
   input  wire  [7:0]           fifo_data_i,
   input  wire  [15:0]          crc_i,
   // Host side.
   input  wire                  tx_ready_i,
   output in_ep_pkg::tx_byte_t  tx_o
);
   import in_ep_pkg::*;

   logic       valid_q;
   logic       last_q;
   logic [7:0] data_q;
   logic [7:0] data_d;
   logic       load;
   logic       consume;

   // Byte source mux.
   always_comb begin
      case (tx_sel_i)
         SEL_DATA:   data_d = fifo_data_i;
         SEL_CRC_LO: data_d = crc_i[7:0];
         SEL_CRC_HI: data_d = crc_i[15:8];
         default:    data_d = tx_pid_i;
      endcase
   end

   // A byte is taken whenever the output stage is empty and the
   // controller offers one. The register keeps the wire steady while
   // the FIFO pointer moves after a consumed data byte.
   assign consume = valid_q && tx_ready_i;
   assign load    = !valid_q && tx_valid_i;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         valid_q <= 1'b0;
      end else if (consume) begin
         valid_q <= 1'b0;
      end else if (load) begin
         valid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (load) begin
         data_q <= data_d;
         last_q <= tx_last_i;
      end
   end

   assign tx_o.valid = valid_q;
   assign tx_o.last  = last_q;
   assign tx_o.data  = data_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the IN endpoint testbench with Verilator and runs it.
# The run counts as passed only if the pass message shows up in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_usb_in_ep -f sim.f \
   && ./obj_dir/Vtb_usb_in_ep | tee /dev/stderr | grep -q "TESTS PASSED" \
   && echo "Simulation result: pass" \
   || { echo "Simulation result: fail"; exit 1; }

//--- sim.f
in_ep_pkg.sv
in_fifo.sv
in_crc16.sv
in_pkt_tx.sv
in_ep_ctrl.sv
usb_in_ep.sv
tb_clk_gen.sv
tb_usb_in_ep.sv

//--- tb_clk_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and reset generator.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
   parameter int HALF_PERIOD_NS = 2,
   parameter int RESET_CYCLES   = 16
) (
   output logic clk_o,
   output logic rstn_o
);

   initial begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
   end

   // Reset is released on a rising edge after RESET_CYCLES clocks.
   initial begin
      rstn_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rstn_o <= 1'b1;
   end

endmodule

`default_nettype wire

//--- tb_usb_in_ep.sv
// ----------------------------------------------------------------------
// Testbench for the USB IN endpoint.
// Host model, CRC16 reference, compare tasks, directed tests
// and a cycle count timeout.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_usb_in_ep;
   import in_ep_pkg::*;

   localparam int MAX_PKT        = 8;
   localparam int BIT_SAMPLES    = 4;
   localparam int TIMEOUT_CYCLES = 4000;

   logic       clk;
   logic       rstn;
   logic [7:0] app_in_data;
   logic       app_in_valid;
   logic       app_in_ready;
   logic       in_token;
   logic       ack;
   logic       hs_timeout;
   logic       tx_ready;
   tx_byte_t   tx;
   logic       busy;
   logic       in_empty;
   logic       in_full;
   int         cycle_cnt;
   // Bytes written but not yet acknowledged, oldest first.
   logic [7:0] pending_q[$];
   logic       exp_toggle;

   tb_clk_gen #(
      .RESET_CYCLES (16)
   ) i_clk_gen (
      .clk_o  (clk),
      .rstn_o (rstn)
   );

   usb_in_ep #(
      .MAX_PKT     (MAX_PKT),
      .BIT_SAMPLES (BIT_SAMPLES)
   ) i_dut (
      .clk_i          (clk),
      .rstn_i         (rstn),
      .app_in_data_i  (app_in_data),
      .app_in_valid_i (app_in_valid),
      .app_in_ready_o (app_in_ready),
      .in_token_i     (in_token),
      .ack_i          (ack),
      .hs_timeout_i   (hs_timeout),
      .tx_ready_i     (tx_ready),
      .tx_o           (tx),
      .busy_o         (busy),
      .in_empty_o     (in_empty),
      .in_full_o      (in_full)
   );

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("TESTS FAILED");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic check_byte(input tx_byte_t got, input tx_byte_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf(
            "Mismatch at time %0t: %s, got v%0b l%0b %h, expected v%0b l%0b %h",
            $time, what, got.valid, got.last, got.data, exp.valid, exp.last, exp.data));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("Mismatch at time %0t: %s, got %0b, expected %0b",
                                 $time, what, got, exp));
      end
   endtask

   function automatic tx_byte_t make_byte(input logic last, input logic [7:0] data);
      tx_byte_t b;
      b.valid = 1'b1;
      b.last  = last;
      b.data  = data;
      return b;
   endfunction

   // Reference USB CRC16 over the first n bytes, already inverted.
   function automatic logic [15:0] crc16_ref(input logic [7:0] bytes_q[$], input int n);
      logic [15:0] crc;
      logic        fb;
      crc = CRC16_INIT;
      for (int b = 0; b < n; b++) begin
         for (int k = 0; k < 8; k++) begin
            fb  = crc[0] ^ bytes_q[b][k];
            crc = {1'b0, crc[15:1]};
            if (fb) begin
               crc = crc ^ CRC16_POLY_REFL;
            end
         end
      end
      return ~crc;
   endfunction

   task automatic write_bytes(input int n);
      logic [7:0] d;
      for (int i = 0; i < n; i++) begin
         d = 8'($urandom);
         @(posedge clk);
         app_in_data  <= d;
         app_in_valid <= 1'b1;
         @(negedge clk);
         while (!app_in_ready) @(negedge clk);
         @(posedge clk);
         app_in_valid <= 1'b0;
         pending_q.push_back(d);
      end
   endtask

   // Token pulse, then the first byte must appear exactly two cycles later.
   task automatic send_token();
      @(posedge clk);
      in_token <= 1'b1;
      @(posedge clk);
      in_token <= 1'b0;
      @(negedge clk);
      check_flag(busy, 1'b1, "busy after token");
      check_flag(tx.valid, 1'b0, "valid one cycle after token");
      @(negedge clk);
      check_flag(tx.valid, 1'b1, "valid two cycles after token");
   endtask

   // Host side of one byte. Extra tokens are pulsed while the byte waits.
   task automatic receive_byte(input tx_byte_t exp, input logic extra_tokens);
      int delay;
      delay = int'($urandom % 4);
      @(negedge clk);
      while (!tx.valid) @(negedge clk);
      check_byte(tx, exp, "packet byte");
      repeat (delay) begin
         @(posedge clk);
         in_token <= extra_tokens && !in_token;
         @(negedge clk);
         check_byte(tx, exp, "byte held until ready");
      end
      @(posedge clk);
      in_token <= 1'b0;
      tx_ready <= 1'b1;
      @(posedge clk);
      tx_ready <= 1'b0;
   endtask

   task automatic run_nak();
      send_token();
      receive_byte(make_byte(1'b1, PID_NAK), 1'b0);
      @(negedge clk);
      check_flag(busy, 1'b0, "busy after NAK");
      check_flag(in_empty, 1'b1, "empty after NAK");
   endtask

   // Receives one data packet and answers with ACK or handshake timeout.
   task automatic run_data(input logic do_ack, input logic extra_tokens);
      int          n;
      logic [15:0] crc;
      pid_e        pid;
      n   = (pending_q.size() < MAX_PKT) ? pending_q.size() : MAX_PKT;
      crc = crc16_ref(pending_q, n);
      pid = exp_toggle ? PID_DATA1 : PID_DATA0;
      send_token();
      receive_byte(make_byte(1'b0, pid), extra_tokens);
      for (int i = 0; i < n; i++) begin
         receive_byte(make_byte(1'b0, pending_q[i]), extra_tokens);
      end
      receive_byte(make_byte(1'b0, crc[7:0]), extra_tokens);
      receive_byte(make_byte(1'b1, crc[15:8]), extra_tokens);
      @(negedge clk);
      check_flag(busy, 1'b1, "busy while waiting for handshake");
      @(posedge clk);
      in_token   <= extra_tokens;
      ack        <= do_ack;
      hs_timeout <= !do_ack;
      @(posedge clk);
      in_token   <= 1'b0;
      ack        <= 1'b0;
      hs_timeout <= 1'b0;
      @(negedge clk);
      check_flag(busy, 1'b0, "busy after handshake");
      if (do_ack) begin
         repeat (n) void'(pending_q.pop_front());
         exp_toggle = !exp_toggle;
      end
      repeat (2) @(negedge clk);
      check_flag(in_empty, pending_q.size() == 0, "empty after handshake");
   endtask

   task automatic check_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_flag(tx.valid, 1'b0, "no byte after transaction");
         check_flag(busy, 1'b0, "idle after transaction");
      end
   endtask

   task automatic test_reset_state();
      @(negedge clk);
      check_flag(tx.valid, 1'b0, "valid after reset");
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(app_in_ready, 1'b0, "write ready right after reset");
      check_flag(in_empty, 1'b1, "empty after reset");
   endtask

   task automatic test_nak_on_empty();
      run_nak();
      check_quiet(4);
   endtask

   // Second packet must carry DATA1.
   task automatic test_data_ack();
      write_bytes(5);
      run_data(1'b1, 1'b0);
      write_bytes(1);
      run_data(1'b1, 1'b0);
   endtask

   task automatic test_timeout_retry();
      write_bytes(3);
      run_data(1'b0, 1'b0);
      run_data(1'b1, 1'b0);
   endtask

   task automatic test_full_toggle();
      write_bytes(MAX_PKT);
      repeat (2 * BIT_SAMPLES) begin
         @(negedge clk);
         check_flag(in_full, 1'b1, "full after MAX_PKT writes");
         check_flag(app_in_ready, 1'b0, "write ready while full");
      end
      run_data(1'b1, 1'b0);
      check_flag(in_full, 1'b0, "full after commit");
      write_bytes(2);
      run_data(1'b1, 1'b0);
      write_bytes(4);
      run_data(1'b1, 1'b0);
   endtask

   task automatic test_busy_tokens();
      write_bytes(6);
      run_data(1'b0, 1'b1);
      run_data(1'b1, 1'b1);
      check_quiet(10);
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         stop_on_error($sformatf("Timeout: tests not finished after %0d cycles", cycle_cnt));
      end
   end

   initial begin
      app_in_data  = '0;
      app_in_valid = 1'b0;
      in_token     = 1'b0;
      ack          = 1'b0;
      hs_timeout   = 1'b0;
      tx_ready     = 1'b0;
      exp_toggle   = 1'b0;
      cycle_cnt    = 0;
      void'($urandom(71));
      @(posedge rstn);
      test_reset_state();
      test_nak_on_empty();
      test_data_ack();
      test_timeout_retry();
      test_full_toggle();
      test_busy_tokens();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- usb_in_ep.sv
// ----------------------------------------------------------------------
// USB full-speed IN endpoint top level.
// Connects the controller, the IN FIFO, the CRC and the byte builder.
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module usb_in_ep #(
   parameter int MAX_PKT     = 8,
   parameter int BIT_SAMPLES = 4
) (
   input  wire                      clk_i,
   input  wire                      rstn_i,
   // Application.
   input  wire  [7:0]               app_in_data_i,
   input  wire                      app_in_valid_i,
   output wire                      app_in_ready_o,
   // Host.
   input  wire                      in_token_i,
   input  wire                      ack_i,
   input  wire                      hs_timeout_i,
   input  wire                      tx_ready_i,
   output wire in_ep_pkg::tx_byte_t tx_o,
   // Status.
   output wire                      busy_o,
   output wire                      in_empty_o,
   output wire                      in_full_o
);
   import in_ep_pkg::*;

   wire          in_req;
   wire          in_ready;
   wire          in_commit;
   wire          in_valid;
   wire [7:0]    in_data;
   wire          crc_clear;
   wire          crc_update;
   wire [15:0]   crc;
   wire tx_sel_e tx_sel;
   wire pid_e    tx_pid;
   wire          tx_valid;
   wire          tx_last;

   in_ep_ctrl #(
      .MAX_PKT (MAX_PKT)
   ) i_ctrl (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .in_token_i   (in_token_i),
      .ack_i        (ack_i),
      .hs_timeout_i (hs_timeout_i),
      .tx_ready_i   (tx_ready_i),
      .in_valid_i   (in_valid),
      .in_empty_i   (in_empty_o),
      .in_req_o     (in_req),
      .in_ready_o   (in_ready),
      .in_commit_o  (in_commit),
      .crc_clear_o  (crc_clear),
      .crc_update_o (crc_update),
      .tx_sel_o     (tx_sel),
      .tx_pid_o     (tx_pid),
      .tx_valid_o   (tx_valid),
      .tx_last_o    (tx_last),
      .busy_o       (busy_o),
      .toggle_o     ()
   );

   in_fifo #(
      .MAX_PKT     (MAX_PKT),
      .BIT_SAMPLES (BIT_SAMPLES)
   ) i_fifo (
      .clk_i          (clk_i),
      .rstn_i         (rstn_i),
      .app_in_data_i  (app_in_data_i),
      .app_in_valid_i (app_in_valid_i),
      .app_in_ready_o (app_in_ready_o),
      .in_req_i       (in_req),
      .in_ready_i     (in_ready),
      .in_commit_i    (in_commit),
      .in_data_o      (in_data),
      .in_valid_o     (in_valid),
      .in_empty_o     (in_empty_o),
      .in_full_o      (in_full_o)
   );

   in_crc16 i_crc (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .crc_clear_i  (crc_clear),
      .crc_update_i (crc_update),
      .crc_data_i   (in_data),
      .crc_o        (crc)
   );

   in_pkt_tx i_pkt_tx (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .tx_sel_i    (tx_sel),
      .tx_pid_i    (tx_pid),
      .tx_valid_i  (tx_valid),
      .tx_last_i   (tx_last),
      .fifo_data_i (in_data),
      .crc_i       (crc),
      .tx_ready_i  (tx_ready_i),
      .tx_o        (tx_o)
   );

endmodule

`default_nettype wire
